/* filelist.f */
+incdir+include
hdl/csr_pkg.sv
hdl/csr_ifs.sv
hdl/csr_decode.sv
hdl/csr_exec.sv
hdl/csr_file.sv
hdl/csr_unit_top.sv
bench/csr_unit_props.sv
bench/csr_unit_tb.sv

/* Makefile */
SIM      = verilator
SIMFLAGS = --binary --timing --assert
TOP      = csr_unit_tb
FILELIST = filelist.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) include/csr_cfg.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "No result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/csr_unit_tb.sv */
`include "csr_cfg.svh"

module csr_unit_tb;

  localparam int N_RMW    = 120;
  localparam int N_ILL    = 40;
  localparam int N_MIX    = 150;
  localparam int N_TOTAL  = 6 + N_RMW + 6 + 4 + N_ILL + N_MIX;
  localparam int WATCHDOG = (N_TOTAL + 20) * 2 * 10;

  localparam logic [31:0] ECALL_INSTR = 32'h0000_0073;
  localparam logic [31:0] MRET_INSTR  = 32'h3020_0073;

  typedef struct packed {
    logic [31:0] issue;
    logic        wen;
    logic [4:0]  rd;
    logic [31:0] rd_data;
    logic        redir;
    logic [31:0] redir_pc;
    logic        ill;
  } exp_t;

  logic        clk;
  logic        rst;
  logic        in_valid;
  logic [31:0] instr;
  logic [31:0] pc;
  logic [31:0] rs1_data;
  logic        out_valid;
  logic [4:0]  rd_addr;
  logic [31:0] rd_data;
  logic        rd_wen;
  logic        redirect_valid;
  logic [31:0] redirect_pc;
  logic        illegal;

  integer      seed = 32'h6309b04a;
  int          cycle = 0;
  int          errors = 0;
  int          tests_pass = 0;
  int          tests_fail = 0;
  int          start_errors = 0;
  exp_t        exp_q[$];
  logic [31:0] m_mstatus, m_mcause, m_mepc, m_mtvec; // Reference CSR state
  logic [11:0] known_addr [6] = '{`CSR_MSTATUS, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE,
                                  `CSR_MVENDORID, `CSR_MARCHID};

  csr_unit_top dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    #WATCHDOG;
    $display("Timeout: expected outputs still pending after %0d time units", WATCHDOG);
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic [31:0] csr_instr(input logic [2:0] f3, input logic [11:0] addr,
                                            input logic [4:0] rs1, input logic [4:0] rd);
    return {addr, rs1, f3, rd, 7'h73};
  endfunction

  function automatic logic [11:0] pick_addr(input logic [31:0] r);
    if (r[2:0] < 3'd6)
      return known_addr[r[2:0]];
    return r[31:20]; // Mostly unknown addresses
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Applies one instruction to the model and drives it
  task automatic issue(input logic [31:0] ins, input logic [31:0] pc_v, input logic [31:0] src);
    exp_t        e;
    logic [2:0]  f3;
    logic [11:0] a;
    logic        is_csr, known, ro, wr;
    logic [31:0] old, nv;
    @(posedge clk);
    f3     = ins[14:12];
    a      = ins[31:20];
    is_csr = (ins[6:0] == 7'h73) && (f3 inside {3'd1, 3'd2, 3'd3});
    known  = 1'b1;
    ro     = 1'b0;
    old    = 32'd0;
    case (a)
      `CSR_MSTATUS:   old = m_mstatus;
      `CSR_MCAUSE:    old = m_mcause;
      `CSR_MEPC:      old = m_mepc;
      `CSR_MTVEC:     old = m_mtvec;
      `CSR_MVENDORID: {old, ro} = {`CSR_VENDOR_ID, 1'b1};
      `CSR_MARCHID:   {old, ro} = {`CSR_ARCH_ID, 1'b1};
      default:        known = 1'b0;
    endcase
    wr = (f3 == 3'd1) || (ins[19:15] != 5'd0);
    e = '0;
    e.issue   = cycle;
    e.ill     = is_csr && (!known || (wr && ro));
    e.wen     = is_csr && !e.ill && (ins[11:7] != 5'd0);
    e.rd      = ins[11:7];
    e.rd_data = old;
    nv = (f3 == 3'd2) ? (old | src) : (f3 == 3'd3) ? (old & ~src) : src;
    if (is_csr && wr && !e.ill)
    begin
      case (a)
        `CSR_MSTATUS: m_mstatus = nv;
        `CSR_MCAUSE:  m_mcause  = nv;
        `CSR_MEPC:    m_mepc    = nv;
        `CSR_MTVEC:   m_mtvec   = nv;
        default: ;
      endcase
    end
    if (ins == ECALL_INSTR)
    begin
      {e.redir, e.redir_pc} = {1'b1, m_mtvec}; // Target is mtvec before the trap
      m_mepc   = pc_v;
      m_mcause = `CSR_CAUSE_ECALL_M;
      m_mstatus[`CSR_MPIE_BIT] = m_mstatus[`CSR_MIE_BIT];
      m_mstatus[`CSR_MIE_BIT]  = 1'b0;
    end
    else if (ins == MRET_INSTR)
    begin
      {e.redir, e.redir_pc} = {1'b1, m_mepc};
      m_mstatus[`CSR_MIE_BIT]  = m_mstatus[`CSR_MPIE_BIT];
      m_mstatus[`CSR_MPIE_BIT] = 1'b1;
    end
    exp_q.push_back(e);
    in_valid <= 1'b1;
    instr    <= ins;
    pc       <= pc_v;
    rs1_data <= src;
  endtask

  task automatic idle();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic finish_test(input string name);
    idle();
    while (exp_q.size() != 0)
      @(posedge clk);
    if (errors == start_errors)
    begin
      tests_pass++;
      $display("test %s: pass", name);
    end
    else
    begin
      tests_fail++;
      $display("test %s: fail, %0d errors", name, errors - start_errors);
    end
    start_errors = errors;
  endtask

  // Issue edge N is sampled at N+1 and read back here at N+3
  always @(posedge clk)
  begin : monitor
    exp_t e;
    cycle <= cycle + 1;
    if (!rst && out_valid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Output valid at %0t with no instruction in flight", $time);
        errors++;
      end
      else
      begin
        e = exp_q.pop_front();
        check("latency", cycle - e.issue, 32'd3);
        check("rd_wen", {31'd0, rd_wen}, {31'd0, e.wen});
        check("illegal", {31'd0, illegal}, {31'd0, e.ill});
        check("redirect_valid", {31'd0, redirect_valid}, {31'd0, e.redir});
        if (e.wen)
        begin
          check("rd_addr", {27'd0, rd_addr}, {27'd0, e.rd});
          check("rd_data", rd_data, e.rd_data);
        end
        if (e.redir)
          check("redirect_pc", redirect_pc, e.redir_pc);
      end
    end
  end

  initial
  begin : stimulus
    logic [31:0] r, p;
    rst      = 1'b1;
    in_valid = 1'b0;
    instr    = 32'd0;
    pc       = 32'd0;
    rs1_data = 32'd0;
    {m_mstatus, m_mcause, m_mepc, m_mtvec} = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < 6; i++)
      issue(csr_instr(3'd2, known_addr[i], 5'd0, 5'd1), 32'd0, rand32());
    finish_test("reset values");

    for (int i = 0; i < N_RMW; i++)
    begin
      r = rand32();
      if (r[31:30] == 2'd0)
        idle();
      issue(csr_instr((r[4:3] == 2'd0) ? 3'd1 : {1'b0, r[4:3]}, known_addr[r[1:0]],
                      r[9:5], r[14:10]), 32'd0, rand32());
    end
    finish_test("read-modify-write and ordering");

    p = rand32();
    issue(csr_instr(3'd1, `CSR_MTVEC, 5'd5, 5'd0), 32'd0, {p[31:2], 2'b00});
    issue(csr_instr(3'd1, `CSR_MSTATUS, 5'd6, 5'd0), 32'd0, 32'd1 << `CSR_MIE_BIT); // MPIE clear
    p = rand32();
    issue(ECALL_INSTR, {p[31:2], 2'b00}, 32'd0);
    issue(csr_instr(3'd2, `CSR_MEPC, 5'd0, 5'd1), 32'd0, 32'd0);
    issue(csr_instr(3'd2, `CSR_MCAUSE, 5'd0, 5'd2), 32'd0, 32'd0);
    issue(csr_instr(3'd2, `CSR_MSTATUS, 5'd0, 5'd3), 32'd0, 32'd0);
    finish_test("trap entry");

    p = rand32();
    issue(csr_instr(3'd1, `CSR_MEPC, 5'd7, 5'd0), 32'd0, {p[31:2], 2'b00});
    // MIE set and MPIE clear so both MRET updates show
    issue(csr_instr(3'd1, `CSR_MSTATUS, 5'd8, 5'd0), 32'd0,
          (rand32() | (32'd1 << `CSR_MIE_BIT)) & ~(32'd1 << `CSR_MPIE_BIT));
    issue(MRET_INSTR, 32'd0, 32'd0);
    issue(csr_instr(3'd2, `CSR_MSTATUS, 5'd0, 5'd4), 32'd0, 32'd0);
    finish_test("trap return");

    for (int i = 0; i < N_ILL; i++)
    begin
      r = rand32();
      issue(csr_instr({1'b0, r[4:3]} | {2'b00, r[4:3] == 2'd0}, pick_addr(r), r[9:5],
                      r[14:10]), 32'd0, rand32());
    end
    finish_test("illegal access");

    for (int i = 0; i < N_MIX; i++)
    begin
      r = rand32();
      p = rand32();
      if (r[31:30] == 2'd0)
        idle();
      case (r[5:3])
        3'd0: issue(ECALL_INSTR, {p[31:2], 2'b00}, 32'd0);
        3'd1: issue(MRET_INSTR, 32'd0, 32'd0);
        3'd2: issue(csr_instr(3'd5, pick_addr(r), r[10:6], r[15:11]), 32'd0, p); // CSRRWI
        default: issue(csr_instr({1'b0, r[7:6]} | {2'b00, r[7:6] == 2'd0}, pick_addr(r),
                                 r[12:8], r[17:13]), 32'd0, p);
      endcase
    end
    finish_test("random mix");

    $display("tests passed %0d, failed %0d, check errors %0d", tests_pass, tests_fail, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* bench/csr_unit_props.sv */
module csr_unit_props (
  input logic clk,
  input logic rst,
  input logic out_valid,
  input logic rd_wen,
  input logic redirect_valid,
  input logic illegal
);

  // Qualifier flags only with a result
  a_flags_need_valid: assert property (@(posedge clk) disable iff (rst)
    (rd_wen || redirect_valid) |-> out_valid)
    else $error("rd_wen or redirect_valid without out_valid");

  a_illegal_no_redirect: assert property (@(posedge clk) disable iff (rst)
    illegal |-> !redirect_valid)
    else $error("illegal together with redirect_valid");

  a_quiet_in_reset: assert property (@(posedge clk)
    rst |=> !(out_valid || rd_wen || redirect_valid || illegal))
    else $error("outputs active while in reset");

endmodule

bind csr_unit_top csr_unit_props u_props (
  .clk            (clk),
  .rst            (rst),
  .out_valid      (out_valid),
  .rd_wen         (rd_wen),
  .redirect_valid (redirect_valid),
  .illegal        (illegal)
);

/* hdl/csr_unit_top.sv */
`include "csr_cfg.svh"

module csr_unit_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  input  logic [31:0]          instr,
  input  logic [`CSR_XLEN-1:0] pc,
  input  logic [`CSR_XLEN-1:0] rs1_data,
  output logic                 out_valid,
  output logic [4:0]           rd_addr,
  output logic [`CSR_XLEN-1:0] rd_data,
  output logic                 rd_wen,
  output logic                 redirect_valid,
  output logic [`CSR_XLEN-1:0] redirect_pc,
  output logic                 illegal
);

  csr_uop_if    uop_link ();
  csr_access_if acc_link ();

  csr_decode u_decode (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .instr    (instr),
    .pc       (pc),
    .rs1_data (rs1_data),
    .uop      (uop_link.src)
  );

  csr_exec u_exec (
    .clk            (clk),
    .rst            (rst),
    .uop            (uop_link.dst),
    .csr            (acc_link.master),
    .out_valid      (out_valid),
    .rd_addr        (rd_addr),
    .rd_data        (rd_data),
    .rd_wen         (rd_wen),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .illegal        (illegal)
  );

  csr_file u_file (
    .clk (clk),
    .rst (rst),
    .acc (acc_link.slave)
  );

endmodule

/* hdl/csr_file.sv */
`include "csr_cfg.svh"

module csr_file (
  input  logic        clk,
  input  logic        rst,
  csr_access_if.slave acc
);

  logic [`CSR_XLEN-1:0]   mstatus_q, mcause_q, mepc_q, mtvec_q;
  logic [`CSR_XLEN-1:0]   mstatus_n, mcause_n, mepc_n, mtvec_n;
  logic [`CSR_ADDR_W-1:0] port_addr [2];
  logic [`CSR_XLEN-1:0]   port_data [2];

  assign port_addr[0] = acc.waddr;
  assign port_data[0] = acc.wdata;
  assign port_addr[1] = acc.waddr_add1;
  assign port_data[1] = acc.wdata_add1;

  always_comb
  begin
    acc.rdata    = '0;
    acc.legal    = 1'b1;
    acc.writable = 1'b1;
    case (acc.raddr)
      `CSR_MSTATUS:   acc.rdata = mstatus_q;
      `CSR_MCAUSE:    acc.rdata = mcause_q;
      `CSR_MEPC:      acc.rdata = mepc_q;
      `CSR_MTVEC:     acc.rdata = mtvec_q;
      `CSR_MVENDORID:
      begin
        acc.rdata    = `CSR_VENDOR_ID;
        acc.writable = 1'b0;
      end
      `CSR_MARCHID:
      begin
        acc.rdata    = `CSR_ARCH_ID;
        acc.writable = 1'b0;
      end
      default:
      begin
        acc.legal    = 1'b0;
        acc.writable = 1'b0;
      end
    endcase
  end

  assign acc.mepc  = mepc_q;
  assign acc.mtvec = mtvec_q;

  always_comb
  begin
    mstatus_n = mstatus_q;
    mcause_n  = mcause_q;
    mepc_n    = mepc_q;
    mtvec_n   = mtvec_q;
    if (acc.commit && acc.wen)
    begin
      for (int p = 0; p < 2; p++) // Later port overrides
      begin
        case (port_addr[p])
          `CSR_MSTATUS: mstatus_n = port_data[p];
          `CSR_MCAUSE:  mcause_n  = port_data[p];
          `CSR_MEPC:    mepc_n    = port_data[p];
          `CSR_MTVEC:   mtvec_n   = port_data[p];
          default: ;
        endcase
      end
    end
    // Trap status goes on top of the data writes
    if (acc.commit && acc.ecall)
    begin
      mstatus_n[`CSR_MPIE_BIT] = mstatus_q[`CSR_MIE_BIT];
      mstatus_n[`CSR_MIE_BIT]  = 1'b0;
    end
    else if (acc.commit && acc.mret)
    begin
      mstatus_n[`CSR_MIE_BIT]  = mstatus_q[`CSR_MPIE_BIT];
      mstatus_n[`CSR_MPIE_BIT] = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mstatus_q <= '0;
      mcause_q  <= '0;
      mepc_q    <= '0;
      mtvec_q   <= '0;
    end
    else
    begin
      mstatus_q <= mstatus_n;
      mcause_q  <= mcause_n;
      mepc_q    <= mepc_n;
      mtvec_q   <= mtvec_n;
    end
  end

endmodule

/* hdl/csr_exec.sv */
`include "csr_cfg.svh"

module csr_exec
  import csr_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  csr_uop_if.dst               uop,
  csr_access_if.master         csr,
  output logic                 out_valid,
  output logic [4:0]           rd_addr,
  output logic [`CSR_XLEN-1:0] rd_data,
  output logic                 rd_wen,
  output logic                 redirect_valid,
  output logic [`CSR_XLEN-1:0] redirect_pc,
  output logic                 illegal
);

  logic                 is_csr;
  logic                 is_ecall;
  logic                 is_mret;
  logic                 will_write;
  logic                 illegal_c;
  logic [`CSR_XLEN-1:0] new_val;

  assign is_csr   = uop.uop.op inside {OP_RW, OP_RS, OP_RC};
  assign is_ecall = uop.uop.op == OP_ECALL;
  assign is_mret  = uop.uop.op == OP_MRET;

  // RS and RC with rs1 = x0 only read
  assign will_write = (uop.uop.op == OP_RW) || (is_csr && uop.uop.rs1_nz);
  assign illegal_c  = is_csr && (!csr.legal || (will_write && !csr.writable));

  always_comb
  begin
    case (uop.uop.op)
      OP_RS:   new_val = csr.rdata | uop.uop.src;
      OP_RC:   new_val = csr.rdata & ~uop.uop.src;
      default: new_val = uop.uop.src;
    endcase
  end

  assign csr.raddr  = uop.uop.addr;
  assign csr.commit = uop.valid;
  assign csr.wen    = (will_write && !illegal_c) || is_ecall;
  assign csr.ecall  = is_ecall;
  assign csr.mret   = is_mret;

  // ECALL pairs mepc on port 0 with mcause on port add1
  assign csr.waddr      = is_ecall ? `CSR_MEPC : uop.uop.addr;
  assign csr.wdata      = is_ecall ? uop.uop.pc : new_val;
  assign csr.waddr_add1 = is_ecall ? `CSR_MCAUSE : uop.uop.addr;
  assign csr.wdata_add1 = is_ecall ? `CSR_CAUSE_ECALL_M : new_val;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      out_valid      <= 1'b0;
      rd_wen         <= 1'b0;
      redirect_valid <= 1'b0;
      illegal        <= 1'b0;
    end
    else
    begin
      out_valid      <= uop.valid;
      rd_wen         <= uop.valid && is_csr && !illegal_c && (uop.uop.rd != 5'd0);
      redirect_valid <= uop.valid && (is_ecall || is_mret);
      illegal        <= uop.valid && illegal_c;
    end
  end

  always_ff @(posedge clk)
  begin
    rd_addr     <= uop.uop.rd;
    rd_data     <= csr.rdata; // Old value
    redirect_pc <= is_ecall ? csr.mtvec : csr.mepc;
  end

endmodule

/* hdl/csr_decode.sv */
`include "csr_cfg.svh"

module csr_decode
  import csr_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  input  logic [31:0]          instr,
  input  logic [`CSR_XLEN-1:0] pc,
  input  logic [`CSR_XLEN-1:0] rs1_data,
  csr_uop_if.src               uop
);

  localparam logic [6:0]  OPC_SYSTEM = 7'b1110011;
  localparam logic [31:0] ENC_ECALL  = 32'h0000_0073;
  localparam logic [31:0] ENC_MRET   = 32'h3020_0073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  csr_op_e    op_c;
  csr_uop_t   uop_c;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  always_comb
  begin
    op_c = OP_NONE;
    if (instr == ENC_ECALL)
      op_c = OP_ECALL;
    else if (instr == ENC_MRET)
      op_c = OP_MRET;
    else if (opcode == OPC_SYSTEM)
    begin
      case (funct3)
        3'd1: op_c = OP_RW;
        3'd2: op_c = OP_RS;
        3'd3: op_c = OP_RC;
        default: op_c = OP_NONE; // Immediate forms and the rest pass as no-ops
      endcase
    end
  end

  always_comb
  begin
    uop_c.op     = op_c;
    uop_c.addr   = instr[31:20];
    uop_c.rd     = instr[11:7];
    uop_c.rs1_nz = |instr[19:15];
    uop_c.src    = rs1_data;
    uop_c.pc     = pc;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      uop.valid <= 1'b0;
    else
      uop.valid <= in_valid;
  end

  always_ff @(posedge clk)
  begin
    if (in_valid)
      uop.uop <= uop_c;
  end

endmodule

/* hdl/csr_ifs.sv */
`include "csr_cfg.svh"

// Decode to execute, one strobe per instruction, no ready
interface csr_uop_if
  import csr_pkg::*;
();
  logic     valid;
  csr_uop_t uop;

  modport src (output valid, output uop);
  modport dst (input valid, input uop);
endinterface

// Execute to CSR file
interface csr_access_if ();
  logic                   commit;
  logic                   wen;
  logic [`CSR_ADDR_W-1:0] waddr;
  logic [`CSR_XLEN-1:0]   wdata;
  logic [`CSR_ADDR_W-1:0] waddr_add1; // Second port, wins on same address
  logic [`CSR_XLEN-1:0]   wdata_add1;
  logic                   ecall;
  logic                   mret;
  logic [`CSR_ADDR_W-1:0] raddr;
  logic [`CSR_XLEN-1:0]   rdata;
  logic                   legal;
  logic                   writable;
  logic [`CSR_XLEN-1:0]   mepc;
  logic [`CSR_XLEN-1:0]   mtvec;

  modport master (
    output commit, wen, waddr, wdata, waddr_add1, wdata_add1, ecall, mret, raddr,
    input  rdata, legal, writable, mepc, mtvec
  );
  modport slave (
    input  commit, wen, waddr, wdata, waddr_add1, wdata_add1, ecall, mret, raddr,
    output rdata, legal, writable, mepc, mtvec
  );
endinterface

/* hdl/csr_pkg.sv */
`include "csr_cfg.svh"

package csr_pkg;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_RW,
    OP_RS,
    OP_RC,
    OP_ECALL,
    OP_MRET
  } csr_op_e;

  // One decoded instruction as it leaves the decode stage
  typedef struct packed {
    csr_op_e                 op;
    logic [`CSR_ADDR_W-1:0]  addr;
    logic [4:0]              rd;
    logic                    rs1_nz; // rs1 index is not x0
    logic [`CSR_XLEN-1:0]    src;
    logic [`CSR_XLEN-1:0]    pc;
  } csr_uop_t;

endpackage

/* include/csr_cfg.svh */
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// Data path and address widths
`define CSR_XLEN   32
`define CSR_ADDR_W 12

// Machine CSR addresses
`define CSR_MSTATUS   12'h300
`define CSR_MTVEC     12'h305
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MVENDORID 12'hF11
`define CSR_MARCHID   12'hF12

`define CSR_MIE_BIT  3 // mstatus.MIE
`define CSR_MPIE_BIT 7 // mstatus.MPIE

`define CSR_VENDOR_ID     32'h79737978
`define CSR_ARCH_ID       32'h015fde77
`define CSR_CAUSE_ECALL_M 32'd11 // Environment call from M-mode

`endif
